//--- flist.f
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/instrDecoder.sv
rtl/cpuController.sv
rtl/registerFile.sv
rtl/execUnit.sv
rtl/cpuTop.sv
test/cpuTb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := cpuTb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
    import cpuPkg::*;

    localparam int TIMEOUT_CYCLES = 20;

    logic  clk;
    logic  reset;
    logic  start;
    logic  load;
    word_t instr;
    word_t result;
    logic  negative;
    logic  overflow;
    logic  zero;
    logic  ready;

    // Reference model state
    word_t modelRegs [8];
    word_t expResult;
    logic  expNeg;
    logic  expOvf;
    logic  expZero;

    int   valueErrors;
    int   otherErrors;
    event checkNow;

    cpuTop dut_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .load     (load),
        .instr    (instr),
        .result   (result),
        .negative (negative),
        .overflow (overflow),
        .zero     (zero),
        .ready    (ready)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Instruction encoders
    function automatic word_t moveImmWord(input regIdx_t rn, input logic [7:0] imm8);
        return {3'b110, 2'b10, rn, imm8};
    endfunction

    function automatic word_t moveRegWord(input regIdx_t rd, input regIdx_t rm, input shift_t sh);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic word_t aluWord(input aluOp_t op, input regIdx_t rn, input regIdx_t rd,
                                      input regIdx_t rm, input shift_t sh);
        return {3'b101, op, rn, rd, sh, rm};
    endfunction

    // Shift by one, per shift code
    function automatic word_t shiftValue(input word_t v, input shift_t code);
        case (code)
            2'd1:    return v << 1;
            2'd2:    return v >> 1;
            2'd3:    return word_t'($signed(v) >>> 1);
            default: return v;
        endcase
    endfunction

    // Reference model, one instruction
    function automatic void applyModel(input word_t ins);
        word_t a;
        word_t b;
        word_t r;
        int    diff;
        a = modelRegs[ins[10:8]];
        b = shiftValue(modelRegs[ins[2:0]], ins[4:3]);
        if (ins[15:13] == 3'b110 && ins[12:11] == 2'b10) begin
            // Result untouched by move immediate
            modelRegs[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
        end else if (ins[15:13] == 3'b110 && ins[12:11] == 2'b00) begin
            expResult = b;
            modelRegs[ins[7:5]] = b;
        end else if (ins[15:13] == 3'b101) begin
            case (ins[12:11])
                2'b00:   r = a + b;
                2'b01:   r = a - b;
                2'b10:   r = a & b;
                default: r = ~b;
            endcase
            expResult = r;
            if (ins[12:11] == 2'b01) begin
                // Signed overflow from the true difference
                diff    = int'($signed(a)) - int'($signed(b));
                expZero = (r == 16'h0000);
                expNeg  = r[15];
                expOvf  = (diff > 32767) || (diff < -32768);
            end else begin
                modelRegs[ins[7:5]] = r;
            end
        end
    endfunction

    // Any of the six legal encodings, random fields
    function automatic word_t randomInstr();
        regIdx_t rn;
        regIdx_t rd;
        regIdx_t rm;
        shift_t  sh;
        rn = regIdx_t'($urandom_range(0, 7));
        rd = regIdx_t'($urandom_range(0, 7));
        rm = regIdx_t'($urandom_range(0, 7));
        sh = shift_t'($urandom_range(0, 3));
        case ($urandom_range(0, 5))
            0:       return moveImmWord(rn, 8'($urandom));
            1:       return moveRegWord(rd, rm, sh);
            2:       return aluWord(OP_ADD, rn, rd, rm, sh);
            3:       return aluWord(OP_CMP, rn, rd, rm, sh);
            4:       return aluWord(OP_AND, rn, rd, rm, sh);
            default: return aluWord(OP_MVN, rn, rd, rm, sh);
        endcase
    endfunction

    // Closing report and end of run
    task automatic finishRun();
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Load, start, then wait for ready; entered 5 ns after a rising edge
    task automatic issueInstr(input word_t ins);
        int waitCycles;
        waitCycles = 0;
        instr = ins;
        load  = 1'b1;
        @(posedge clk);
        #5;
        load  = 1'b0;
        start = 1'b1;
        @(posedge clk);
        #5;
        start = 1'b0;
        // Busy while in Decode
        assert (!ready) else begin
            otherErrors++;
            $display("ready stayed high after start at %0t", $time);
        end
        while (!ready && waitCycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #5;
            waitCycles++;
        end
        if (!ready) begin
            otherErrors++;
            $display("Timeout at %0t: ready did not return for instruction %h", $time, ins);
            finishRun();
        end else begin
            applyModel(ins);
            -> checkNow;
        end
    endtask

    // Compare in Idle against the model
    always @(checkNow) begin
        assert (result === expResult) else begin
            valueErrors++;
            $display("FAILED time=%0t signal=result expected=%h actual=%h",
                     $time, expResult, result);
        end
        assert (negative === expNeg) else begin
            valueErrors++;
            $display("FAILED time=%0t signal=negative expected=%b actual=%b",
                     $time, expNeg, negative);
        end
        assert (overflow === expOvf) else begin
            valueErrors++;
            $display("FAILED time=%0t signal=overflow expected=%b actual=%b",
                     $time, expOvf, overflow);
        end
        assert (zero === expZero) else begin
            valueErrors++;
            $display("FAILED time=%0t signal=zero expected=%b actual=%b",
                     $time, expZero, zero);
        end
    end

    initial begin
        int i;
        void'($urandom(39));
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        load        = 1'b0;
        instr       = '0;
        valueErrors = 0;
        otherErrors = 0;
        expResult   = '0;
        expNeg      = 1'b0;
        expOvf      = 1'b0;
        expZero     = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        // State right after reset
        assert (ready) else begin
            otherErrors++;
            $display("ready is low after reset at %0t", $time);
        end
        -> checkNow;
        // Fill all registers, mix of signs
        for (i = 0; i < 8; i++) begin
            issueInstr(moveImmWord(regIdx_t'(i), 8'(i * 37 - 120)));
        end
        for (i = 0; i < 8; i++) begin
            issueInstr(moveRegWord(regIdx_t'(i), regIdx_t'(i), 2'd0));
        end
        // Each shift code, negative and positive source, into R0
        issueInstr(moveImmWord(3'd7, 8'h9C));
        issueInstr(moveImmWord(3'd6, 8'h55));
        for (i = 0; i < 4; i++) begin
            issueInstr(moveRegWord(3'd0, 3'd7, shift_t'(i)));
            issueInstr(moveRegWord(3'd0, 3'd6, shift_t'(i)));
        end
        // Random ADD, AND, MVN with readback of Rd
        for (i = 0; i < 30; i++) begin
            instr = aluWord(aluOp_t'(($urandom_range(0, 2) == 0) ? OP_ADD :
                            ($urandom_range(0, 1) == 0) ? OP_AND : OP_MVN),
                            regIdx_t'($urandom_range(0, 7)), regIdx_t'($urandom_range(0, 7)),
                            regIdx_t'($urandom_range(0, 7)), shift_t'($urandom_range(0, 3)));
            issueInstr(instr);
            issueInstr(moveRegWord(instr[7:5], instr[7:5], 2'd0));
        end
        // CMP on equal operands
        issueInstr(moveImmWord(3'd1, 8'd5));
        issueInstr(moveImmWord(3'd2, 8'd5));
        issueInstr(aluWord(OP_CMP, 3'd1, 3'd0, 3'd2, 2'd0));
        // Negative difference, 3 - 5
        issueInstr(moveImmWord(3'd3, 8'd3));
        issueInstr(aluWord(OP_CMP, 3'd3, 3'd0, 3'd1, 2'd0));
        // 0x8000 from -128 shifted left eight times, minus one overflows
        issueInstr(moveImmWord(3'd4, 8'h80));
        repeat (8) issueInstr(moveRegWord(3'd4, 3'd4, 2'd1));
        issueInstr(moveImmWord(3'd5, 8'd1));
        issueInstr(aluWord(OP_CMP, 3'd4, 3'd0, 3'd5, 2'd0));
        // Operands unchanged by CMP
        issueInstr(moveRegWord(3'd4, 3'd4, 2'd0));
        issueInstr(moveRegWord(3'd5, 3'd5, 2'd0));
        // Rd of each CMP keeps its old contents
        issueInstr(moveRegWord(3'd0, 3'd0, 2'd0));
        // Flags hold across non-CMP ALU ops
        issueInstr(aluWord(OP_ADD, 3'd1, 3'd6, 3'd2, 2'd0));
        issueInstr(aluWord(OP_AND, 3'd4, 3'd6, 3'd3, 2'd1));
        issueInstr(aluWord(OP_MVN, 3'd0, 3'd6, 3'd5, 2'd3));
        // Random mix
        for (i = 0; i < 200; i++) begin
            issueInstr(randomInstr());
        end
        // Let the last compare run
        @(posedge clk);
        finishRun();
    end

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  logic          load,
    input  cpuPkg::word_t instr,
    output cpuPkg::word_t result,
    output logic          negative,
    output logic          overflow,
    output logic          zero,
    output logic          ready
);
    import cpuPkg::*;

    opcode_t opcode;
    aluOp_t  op;
    shift_t  shift;
    word_t   imm;
    regIdx_t regNum;
    word_t   readData;

    // Control bus from the controller to the datapath
    ctrlIf ctrlBus ();

    instrDecoder iDecoder (
        .clk    (clk),
        .reset  (reset),
        .load   (load),
        .instr  (instr),
        .ctrl   (ctrlBus.decoder),
        .opcode (opcode),
        .op     (op),
        .shift  (shift),
        .imm    (imm),
        .regNum (regNum)
    );

    cpuController iController (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .opcode (opcode),
        .op     (op),
        .ready  (ready),
        .ctrl   (ctrlBus.controller)
    );

    // Result loops back as the writeback source
    registerFile iRegFile (
        .clk      (clk),
        .ctrl     (ctrlBus.regFile),
        .regNum   (regNum),
        .imm      (imm),
        .result   (result),
        .readData (readData)
    );

    execUnit iExec (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrlBus.exec),
        .readData (readData),
        .shift    (shift),
        .op       (op),
        .result   (result),
        .negative (negative),
        .overflow (overflow),
        .zero     (zero)
    );

endmodule

//--- rtl/execUnit.sv
`timescale 1ns/1ns

module execUnit (
    input  logic           clk,
    input  logic           reset,
    ctrlIf.exec            ctrl,
    input  cpuPkg::word_t  readData,
    input  cpuPkg::shift_t shift,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result,
    output logic           negative,
    output logic           overflow,
    output logic           zero
);
    import cpuPkg::*;

    word_t regA;
    word_t regB;
    word_t aIn;
    word_t bIn;
    word_t aluOut;
    logic  subOverflow;

    // Operand registers
    always_ff @(posedge clk) begin
        if (ctrl.loadA) begin
            regA <= readData;
        end
        if (ctrl.loadB) begin
            regB <= readData;
        end
    end

    assign aIn = ctrl.zeroA ? '0 : regA;

    // Shifter on B, one bit at most
    always_comb begin
        case (shift)
            2'd0:    bIn = regB;
            2'd1:    bIn = regB << 1;
            2'd2:    bIn = regB >> 1;
            // Arithmetic right keeps the sign bit
            default: bIn = {regB[DATA_W-1], regB[DATA_W-1:1]};
        endcase
    end

    // ALU
    always_comb begin
        case (op)
            OP_ADD:  aluOut = aIn + bIn;
            OP_CMP:  aluOut = aIn - bIn;
            OP_AND:  aluOut = aIn & bIn;
            default: aluOut = ~bIn;
        endcase
    end

    // Signed overflow of A - B
    // Operand signs differ and the difference takes the sign of B
    assign subOverflow = (aIn[DATA_W-1] != bIn[DATA_W-1]) &&
                         (aluOut[DATA_W-1] != aIn[DATA_W-1]);

    // Result register C and status flags
    always_ff @(posedge clk) begin
        if (reset) begin
            result   <= '0;
            negative <= 1'b0;
            overflow <= 1'b0;
            zero     <= 1'b0;
        end else begin
            if (ctrl.loadC) begin
                result <= aluOut;
            end
            if (ctrl.loadStatus) begin
                zero     <= (aluOut == '0);
                negative <= aluOut[DATA_W-1];
                overflow <= subOverflow;
            end
        end
    end

    // Flags only follow a subtraction, i.e. CMP
    statusOnSubtract: assert property (@(posedge clk) disable iff (reset)
        ctrl.loadStatus |-> (op == OP_CMP));

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic            clk,
    ctrlIf.regFile          ctrl,
    input  cpuPkg::regIdx_t regNum,
    input  cpuPkg::word_t   imm,
    input  cpuPkg::word_t   result,
    output cpuPkg::word_t   readData
);
    import cpuPkg::*;

    // Eight general registers, not reset
    word_t regs [2**REG_IDX_W];
    word_t writeData;

    // Writeback source
    always_comb begin
        case (ctrl.wbSel)
            wbImm:   writeData = imm;
            default: writeData = result;
        endcase
    end

    // Single write port
    always_ff @(posedge clk) begin
        if (ctrl.writeEn) begin
            regs[regNum] <= writeData;
        end
    end

    // Combinational read at the same register number
    assign readData = regs[regNum];

    // Writes carry defined data, from either the decoder or the execution unit
    writeDataKnown: assert property (@(posedge clk)
        ctrl.writeEn |-> !$isunknown(writeData));

endmodule

//--- rtl/cpuController.sv
`timescale 1ns/1ns

module cpuController (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  cpuPkg::opcode_t opcode,
    input  cpuPkg::aluOp_t  op,
    output logic            ready,
    ctrlIf.controller       ctrl
);
    import cpuPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       isMoveImm;
    logic       isMoveReg;
    logic       isAlu;
    logic       isCmp;

    // Instruction class decode
    assign isMoveImm = (opcode == OPC_MOVE) && (op == OP_MOVE_IMM);
    assign isMoveReg = (opcode == OPC_MOVE) && (op == OP_MOVE_REG);
    assign isAlu     = (opcode == OPC_ALU);
    assign isCmp     = isAlu && (op == OP_CMP);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Next state
    always_comb begin
        nextState = Idle;
        case (state)
            Idle:      nextState = start ? Decode : Idle;
            Decode: begin
                // Unknown encodings fall back to Idle
                if (isMoveImm) begin
                    nextState = WriteImm;
                end else if (isMoveReg) begin
                    nextState = LoadB;
                end else if (isAlu) begin
                    nextState = LoadA;
                end
            end
            LoadA:     nextState = LoadB;
            LoadB:     nextState = Execute;
            // CMP only touches the flags, no writeback
            Execute:   nextState = isCmp ? Idle : WriteBack;
            default:   nextState = Idle;
        endcase
    end

    // Control outputs, decoded from state only
    always_comb begin
        ctrl.regSel     = selRn;
        ctrl.writeEn    = 1'b0;
        ctrl.wbSel      = wbResult;
        ctrl.loadA      = 1'b0;
        ctrl.loadB      = 1'b0;
        ctrl.loadC      = 1'b0;
        ctrl.loadStatus = 1'b0;
        ctrl.zeroA      = 1'b0;
        case (state)
            // Rn into A
            LoadA: ctrl.loadA = 1'b1;
            LoadB: begin
                ctrl.regSel = selRm;
                ctrl.loadB  = 1'b1;
            end
            Execute: begin
                ctrl.loadC      = 1'b1;
                ctrl.loadStatus = isCmp;
                // Move register is 0 + shifted Rm
                ctrl.zeroA      = isMoveReg;
            end
            WriteBack: begin
                ctrl.regSel  = selRd;
                ctrl.writeEn = 1'b1;
            end
            // Immediate into Rn
            WriteImm: begin
                ctrl.writeEn = 1'b1;
                ctrl.wbSel   = wbImm;
            end
            default: ;
        endcase
    end

    assign ready = (state == Idle);

    // State register stays inside the encoded set
    stateLegal: assert property (@(posedge clk) disable iff (reset)
        state inside {Idle, Decode, WriteImm, LoadA, LoadB, Execute, WriteBack});

    // Flag load and register write belong to different instructions
    noWriteWithStatus: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.writeEn && ctrl.loadStatus));

    // Start taken in Idle makes the core busy on the next cycle
    readyOnlyIdle: assert property (@(posedge clk) disable iff (reset)
        (ready && start) |=> !ready);

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  logic            clk,
    input  logic            reset,
    input  logic            load,
    input  cpuPkg::word_t   instr,
    ctrlIf.decoder          ctrl,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::aluOp_t  op,
    output cpuPkg::shift_t  shift,
    output cpuPkg::word_t   imm,
    output cpuPkg::regIdx_t regNum
);
    import cpuPkg::*;

    word_t   instrReg;
    regIdx_t rn;
    regIdx_t rd;
    regIdx_t rm;

    // Instruction register
    // Held stable for the whole instruction since load is only legal in Idle
    always_ff @(posedge clk) begin
        if (reset) begin
            instrReg <= '0;
        end else if (load) begin
            instrReg <= instr;
        end
    end

    // Field slicing
    assign opcode = instrReg[15:13];
    assign op     = instrReg[12:11];
    assign rn     = instrReg[10:8];
    assign rd     = instrReg[7:5];
    assign shift  = instrReg[4:3];
    assign rm     = instrReg[2:0];

    // imm8 sign extended to a full word
    assign imm = {{(DATA_W - 8){instrReg[7]}}, instrReg[7:0]};

    // One register number for both read and write
    always_comb begin
        case (ctrl.regSel)
            selRm:   regNum = rm;
            selRd:   regNum = rd;
            default: regNum = rn;
        endcase
    end

endmodule

//--- rtl/ctrlIf.sv
`timescale 1ns/1ns

interface ctrlIf;
    import cpuPkg::*;

    // Register number select for the decoder
    regSel_t regSel;

    // Register file write control
    logic   writeEn;
    wbSel_t wbSel;

    // Execution unit loads
    logic loadA;
    logic loadB;
    logic loadC;
    logic loadStatus;
    // Forces operand A to zero for move register
    logic zeroA;

    modport controller (
        output regSel, writeEn, wbSel, loadA, loadB, loadC, loadStatus, zeroA
    );

    modport decoder (input regSel);

    modport regFile (input writeEn, wbSel);

    modport exec (input loadA, loadB, loadC, loadStatus, zeroA);

endinterface

//--- rtl/cpuPkg.sv
package cpuPkg;

    // Datapath and register-number widths
    localparam int DATA_W    = 16;
    localparam int REG_IDX_W = 3;

    typedef logic [DATA_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] regIdx_t;

    // Shift code: 0 pass, 1 LSL, 2 LSR, 3 ASR, all by one bit
    typedef logic [1:0] shift_t;

    // ALU code comes straight from the op field
    typedef logic [1:0] aluOp_t;

    typedef logic [2:0] opcode_t;

    // Instruction classes
    localparam opcode_t OPC_MOVE = 3'b110;
    localparam opcode_t OPC_ALU  = 3'b101;

    // Move class op field
    localparam aluOp_t OP_MOVE_IMM = 2'b10;
    localparam aluOp_t OP_MOVE_REG = 2'b00;

    // ALU class op field, doubles as ALU function select
    localparam aluOp_t OP_ADD = 2'b00;
    localparam aluOp_t OP_CMP = 2'b01;
    localparam aluOp_t OP_AND = 2'b10;
    localparam aluOp_t OP_MVN = 2'b11;

    // Which instruction field names the register file port
    typedef enum logic [1:0] {selRn, selRm, selRd} regSel_t;

    // Writeback source
    typedef enum logic {wbImm, wbResult} wbSel_t;

    // Controller states, one instruction in flight
    typedef enum logic [2:0] {
        Idle, Decode, WriteImm, LoadA, LoadB, Execute, WriteBack
    } ctrlState_t;

endpackage
